//--- src/cpu_macros.svh
/* CPU back end widths and depths
   Shared by the pipeline registers, data memory and register file */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Data path word and address width
`define CPU_DATA_W 16

// Register file address width and register count
`define CPU_REG_AW 4
`define CPU_REG_N (1 << `CPU_REG_AW)

// Data memory word address width and depth
`define CPU_DMEM_AW 8
`define CPU_DMEM_WORDS (1 << `CPU_DMEM_AW)

`endif

//--- src/cpu_pkg.sv
/* CPU back end control types
   Write-back byte and memory control pair carried down the pipeline */
`include "cpu_macros.svh"

package cpu_pkg;

  //////////////////////////////
  // Write-back control byte
  //////////////////////////////
  // Field order matches the decode stage's WB byte, MSB first
  typedef struct packed {
    logic [`CPU_REG_AW-1:0] reg_rd; // Destination register
    logic                   reg_write; // Register file write enable
    logic                   mem_to_reg; // Write back the load data
    logic                   hlt;      // Halt instruction
    logic                   pcs;      // Write back the next PC
  } wb_ctrl_t;

  //////////////////////////////
  // Memory stage controls
  //////////////////////////////
  typedef struct packed {
    logic mem_read;   // Load from data memory
    logic mem_write;  // Store to data memory
  } mem_ctrl_t;

endpackage

//--- src/ex_mem_pipe_reg.sv
/* EX/MEM pipeline register
   Latches execute results each cycle, flush or halt turns controls into a bubble */
`include "cpu_macros.svh"

module ex_mem_pipe_reg
  import cpu_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  flush,             // Cancel the incoming instruction
  input  logic [`CPU_DATA_W-1:0] ex_pc_next,
  input  logic [`CPU_DATA_W-1:0] ex_alu_out,
  input  logic [`CPU_DATA_W-1:0] ex_store_data,
  input  mem_ctrl_t             ex_mem_ctrl,
  input  wb_ctrl_t              ex_wb_ctrl,
  input  logic                  halted,            // Core stopped, from write-back
  output logic [`CPU_DATA_W-1:0] ex_mem_pc_next,
  output logic [`CPU_DATA_W-1:0] ex_mem_alu_out,
  output logic [`CPU_DATA_W-1:0] ex_mem_store_data,
  output mem_ctrl_t             ex_mem_mem_ctrl,
  output wb_ctrl_t              ex_mem_wb_ctrl
);

  mem_ctrl_t mem_ctrl_q;  // Captured memory controls
  wb_ctrl_t  wb_ctrl_q;   // Captured write-back controls

  //////////////////////////////
  // Data fields
  //////////////////////////////
  // Captured even for a bubble, the controls decide if they matter
  always_ff @(posedge clk) begin
    if (rst) begin
      ex_mem_pc_next    <= '0;
      ex_mem_alu_out    <= '0;
      ex_mem_store_data <= '0;
    end else begin
      ex_mem_pc_next    <= ex_pc_next;
      ex_mem_alu_out    <= ex_alu_out;
      ex_mem_store_data <= ex_store_data;
    end
  end

  //////////////////////////////
  // Control fields
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      mem_ctrl_q <= '0; // Bubble, no store and no write-back
      wb_ctrl_q  <= '0;
    end else begin
      mem_ctrl_q <= ex_mem_ctrl;
      wb_ctrl_q  <= ex_wb_ctrl;
    end
  end

  // Once halted, every held instruction is cancelled, including the one in flight
  assign ex_mem_mem_ctrl = halted ? '0 : mem_ctrl_q;
  assign ex_mem_wb_ctrl  = halted ? '0 : wb_ctrl_q;

endmodule

//--- src/data_memory.sv
/* Data memory, word addressed
   Store on the clock edge, load returned combinationally */
`include "cpu_macros.svh"

module data_memory
  import cpu_pkg::*;
(
  input  logic                   clk,
  input  logic [`CPU_DATA_W-1:0] addr,        // ALU result, low bits used
  input  logic [`CPU_DATA_W-1:0] store_data,
  input  mem_ctrl_t              mem_ctrl,
  output logic [`CPU_DATA_W-1:0] load_data
);

  //////////////////////////////
  // Storage
  //////////////////////////////
  // Contents are undefined until written, as in a real RAM
  logic [`CPU_DATA_W-1:0] mem [`CPU_DMEM_WORDS];

  logic [`CPU_DMEM_AW-1:0] word_idx;  // Word index into the array

  assign word_idx = addr[`CPU_DMEM_AW-1:0];

  //////////////////////////////
  // Store port
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (mem_ctrl.mem_write) begin
      mem[word_idx] <= store_data;  // Lands at the end of the MEM cycle
    end
  end

  //////////////////////////////
  // Load port
  //////////////////////////////
  // Zero when no load, so a stale word never reaches MEM/WB
  always_comb begin
    if (mem_ctrl.mem_read) begin
      load_data = mem[word_idx];
    end else begin
      load_data = '0;
    end
  end

endmodule

//--- src/mem_wb_pipe_reg.sv
/* MEM/WB pipeline register
   Carries next PC, ALU result, load data and WB controls into write-back */
`include "cpu_macros.svh"

module mem_wb_pipe_reg
  import cpu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`CPU_DATA_W-1:0] ex_mem_pc_next,   // Next PC from EX/MEM
  input  logic [`CPU_DATA_W-1:0] ex_mem_alu_out,   // ALU result from EX/MEM
  input  logic [`CPU_DATA_W-1:0] mem_data,         // Load data from data memory
  input  wb_ctrl_t               ex_mem_wb_ctrl,
  output logic [`CPU_DATA_W-1:0] mem_wb_pc_next,
  output logic [`CPU_DATA_W-1:0] mem_wb_alu_out,
  output logic [`CPU_DATA_W-1:0] mem_wb_mem_data,
  output wb_ctrl_t               mem_wb_wb_ctrl
);

  //////////////////////////////
  // Data words
  //////////////////////////////
  // No enable, the pipeline advances every clock
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_wb_pc_next  <= '0;
      mem_wb_alu_out  <= '0;
      mem_wb_mem_data <= '0;
    end else begin
      mem_wb_pc_next  <= ex_mem_pc_next;
      mem_wb_alu_out  <= ex_mem_alu_out;
      mem_wb_mem_data <= mem_data;
    end
  end

  //////////////////////////////
  // Write-back controls
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_wb_wb_ctrl <= '0;   // Nothing to write after reset
    end else begin
      mem_wb_wb_ctrl.reg_rd     <= ex_mem_wb_ctrl.reg_rd;
      mem_wb_wb_ctrl.reg_write  <= ex_mem_wb_ctrl.reg_write;
      mem_wb_wb_ctrl.mem_to_reg <= ex_mem_wb_ctrl.mem_to_reg;
      mem_wb_wb_ctrl.hlt        <= ex_mem_wb_ctrl.hlt;
      mem_wb_wb_ctrl.pcs        <= ex_mem_wb_ctrl.pcs;
    end
  end

endmodule

//--- src/write_back_regfile.sv
/* Write-back stage and register file
   Selects the WB value, writes 16 registers with r0 at zero, bypasses reads, latches halt */
`include "cpu_macros.svh"

module write_back_regfile
  import cpu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`CPU_DATA_W-1:0] mem_wb_pc_next,
  input  logic [`CPU_DATA_W-1:0] mem_wb_alu_out,
  input  logic [`CPU_DATA_W-1:0] mem_wb_mem_data,
  input  wb_ctrl_t               mem_wb_wb_ctrl,
  input  logic [`CPU_REG_AW-1:0] rd_addr_a,        // Read port A address
  input  logic [`CPU_REG_AW-1:0] rd_addr_b,        // Read port B address
  output logic [`CPU_DATA_W-1:0] rd_data_a,
  output logic [`CPU_DATA_W-1:0] rd_data_b,
  output logic                   wb_we,            // Register write this cycle
  output logic [`CPU_REG_AW-1:0] wb_rd,
  output logic [`CPU_DATA_W-1:0] wb_data,
  output logic                   halted            // Sticky until reset
);

  logic [`CPU_DATA_W-1:0] regs [`CPU_REG_N];  // Register array, entry 0 stays zero

  //////////////////////////////
  // Write-back select
  //////////////////////////////
  // PCS wins over load data, load data over the ALU result
  always_comb begin
    if (mem_wb_wb_ctrl.pcs) begin
      wb_data = mem_wb_pc_next;     // Link value for calls
    end else if (mem_wb_wb_ctrl.mem_to_reg) begin
      wb_data = mem_wb_mem_data;
    end else begin
      wb_data = mem_wb_alu_out;
    end
  end

  assign wb_rd = mem_wb_wb_ctrl.reg_rd;

  // Writes to r0 are dropped, nothing is written once the core has halted
  assign wb_we = mem_wb_wb_ctrl.reg_write && (wb_rd != '0) && !halted;

  //////////////////////////////
  // Register array
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `CPU_REG_N; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_we) begin
      regs[wb_rd] <= wb_data;
    end
  end

  //////////////////////////////
  // Read ports with bypass
  //////////////////////////////
  // wb_we is already low for r0, so r0 always reads the zero entry
  always_comb begin
    if (wb_we && (wb_rd == rd_addr_a)) begin
      rd_data_a = wb_data;           // Same-cycle write forwarded
    end else begin
      rd_data_a = regs[rd_addr_a];
    end
    if (wb_we && (wb_rd == rd_addr_b)) begin
      rd_data_b = wb_data;
    end else begin
      rd_data_b = regs[rd_addr_b];
    end
  end

  //////////////////////////////
  // Halt latch
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      halted <= 1'b0;
    end else if (mem_wb_wb_ctrl.hlt) begin
      halted <= 1'b1;   // HLT reached write-back
    end
  end

endmodule

//--- src/cpu_backend_top.sv
/* CPU back end top level
   EX/MEM register, data memory, MEM/WB register and write-back with register file */
`include "cpu_macros.svh"

module cpu_backend_top
  import cpu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   flush,
  input  logic [`CPU_DATA_W-1:0] ex_pc_next,      // Execute stage results
  input  logic [`CPU_DATA_W-1:0] ex_alu_out,
  input  logic [`CPU_DATA_W-1:0] ex_store_data,
  input  mem_ctrl_t              ex_mem_ctrl,
  input  wb_ctrl_t               ex_wb_ctrl,
  input  logic [`CPU_REG_AW-1:0] rd_addr_a,       // Decode stage read addresses
  input  logic [`CPU_REG_AW-1:0] rd_addr_b,
  output logic [`CPU_DATA_W-1:0] rd_data_a,
  output logic [`CPU_DATA_W-1:0] rd_data_b,
  output logic                   wb_we,
  output logic [`CPU_REG_AW-1:0] wb_rd,
  output logic [`CPU_DATA_W-1:0] wb_data,
  output logic                   halted
);

  // EX/MEM outputs
  logic [`CPU_DATA_W-1:0] ex_mem_pc_next;
  logic [`CPU_DATA_W-1:0] ex_mem_alu_out;
  logic [`CPU_DATA_W-1:0] ex_mem_store_data;
  mem_ctrl_t              ex_mem_mem_ctrl;
  wb_ctrl_t               ex_mem_wb_ctrl;
  logic [`CPU_DATA_W-1:0] mem_data;           // Load data from memory

  // MEM/WB outputs
  logic [`CPU_DATA_W-1:0] mem_wb_pc_next;
  logic [`CPU_DATA_W-1:0] mem_wb_alu_out;
  logic [`CPU_DATA_W-1:0] mem_wb_mem_data;
  wb_ctrl_t               mem_wb_wb_ctrl;

  ex_mem_pipe_reg i_ex_mem (
    .clk, .rst, .flush,
    .ex_pc_next, .ex_alu_out, .ex_store_data, .ex_mem_ctrl, .ex_wb_ctrl,
    .halted,                                   // Fed back from write-back
    .ex_mem_pc_next, .ex_mem_alu_out, .ex_mem_store_data,
    .ex_mem_mem_ctrl, .ex_mem_wb_ctrl
  );

  data_memory i_dmem (
    .clk,
    .addr       (ex_mem_alu_out),
    .store_data (ex_mem_store_data),
    .mem_ctrl   (ex_mem_mem_ctrl),
    .load_data  (mem_data)
  );

  mem_wb_pipe_reg i_mem_wb (
    .clk, .rst,
    .ex_mem_pc_next, .ex_mem_alu_out, .mem_data, .ex_mem_wb_ctrl,
    .mem_wb_pc_next, .mem_wb_alu_out, .mem_wb_mem_data, .mem_wb_wb_ctrl
  );

  write_back_regfile i_wb (
    .clk, .rst,
    .mem_wb_pc_next, .mem_wb_alu_out, .mem_wb_mem_data, .mem_wb_wb_ctrl,
    .rd_addr_a, .rd_addr_b, .rd_data_a, .rd_data_b,
    .wb_we, .wb_rd, .wb_data, .halted
  );

endmodule

//--- bench/cpu_backend_sva.sv
/* Bound assertions for the CPU back end
   Write-back enable, halt latch and flush bubble rules */
`include "cpu_macros.svh"

module cpu_backend_sva (
  input logic                   clk,
  input logic                   rst,
  input logic                   wb_we,
  input logic [`CPU_REG_AW-1:0] wb_rd,
  input logic                   halted,
  input logic                   flush,
  input logic [1:0]             mem_ctrl,   // EX/MEM memory controls
  input logic [7:0]             wb_ctrl     // EX/MEM write-back byte
);
  timeunit 1ns;
  timeprecision 100ps;

  //////////////////////////////
  // Write-back
  //////////////////////////////
  a_no_r0_write : assert property (@(posedge clk) disable iff (rst)
    wb_we |-> (wb_rd != '0)) else $error("wb_we raised for r0");

  a_no_write_after_halt : assert property (@(posedge clk) disable iff (rst)
    halted |=> !wb_we) else $error("register write after halt");

  // Only a reset clears the latch
  a_halt_sticky : assert property (@(posedge clk)
    (!$past(rst) && $past(halted)) |-> halted) else $error("halted fell without rst");

  //////////////////////////////
  // EX/MEM bubble
  //////////////////////////////
  a_flush_bubble : assert property (@(posedge clk) disable iff (rst)
    flush |=> (mem_ctrl == '0 && wb_ctrl == '0)) else $error("flush left controls set");

endmodule

bind write_back_regfile cpu_backend_sva i_wb_sva (
  .clk, .rst, .wb_we, .wb_rd, .halted,
  .flush (1'b0), .mem_ctrl (2'b00), .wb_ctrl (8'h00)
);

bind ex_mem_pipe_reg cpu_backend_sva i_ex_mem_sva (
  .clk, .rst, .wb_we (1'b0), .wb_rd (4'h0), .halted, .flush,
  .mem_ctrl (ex_mem_mem_ctrl), .wb_ctrl (ex_mem_wb_ctrl)
);

//--- bench/cpu_backend_tb.sv
/* CPU back end testbench
   Table-driven stimulus checked against a cycle model of the MEM and WB stages */
`include "cpu_macros.svh"

module cpu_backend_tb
  import cpu_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NROWS          = 24;
  localparam int TIMEOUT_CYCLES = 2 * NROWS + 20;   // Reset and drain fit well inside
  localparam logic [31:0] SEED  = 32'he3aa_6327;

  typedef struct packed {
    logic                   flush;
    logic                   rnd;       // Replace data fields with LCG values
    logic [`CPU_DATA_W-1:0] pc_next;
    logic [`CPU_DATA_W-1:0] alu;
    logic [`CPU_DATA_W-1:0] store;
    mem_ctrl_t              mc;        // {mem_read, mem_write}
    wb_ctrl_t               wc;        // {reg_rd, reg_write, mem_to_reg, hlt, pcs}
    logic [`CPU_REG_AW-1:0] ra;
    logic [`CPU_REG_AW-1:0] rb;
  } row_t;

  localparam int ROW_W = $bits(row_t);

  //////////////////////////////
  // Stimulus table
  //////////////////////////////
  // flush, rnd, pc_next, alu, store, mem ctrl, wb ctrl, read a, read b
  localparam logic [ROW_W-1:0] TABLE [NROWS] = '{
    {1'b0, 1'b0, 16'h0000, 16'h0000, 16'h0000, 2'b00, 8'h00, 4'h0, 4'h0},  // Idle
    {1'b0, 1'b0, 16'h0002, 16'h1234, 16'h0000, 2'b00, 8'h18, 4'h0, 4'h0},  // r1 = ALU
    {1'b0, 1'b1, 16'h0003, 16'h0000, 16'h0000, 2'b00, 8'h28, 4'h1, 4'h2},  // r2 = random
    {1'b0, 1'b0, 16'h0004, 16'h0040, 16'hbeef, 2'b01, 8'h00, 4'h1, 4'h0},  // Store, r1 bypass
    {1'b0, 1'b0, 16'h0005, 16'h0040, 16'h0000, 2'b10, 8'h5c, 4'h2, 4'h1},  // Load right after
    {1'b0, 1'b0, 16'h0101, 16'h0040, 16'h0000, 2'b10, 8'h6d, 4'h5, 4'h0},  // PCS wins
    {1'b1, 1'b0, 16'h0007, 16'h0040, 16'h1111, 2'b01, 8'h78, 4'h5, 4'h6},  // Flushed store
    {1'b0, 1'b0, 16'h0008, 16'h5555, 16'h0000, 2'b00, 8'h08, 4'h6, 4'h0},  // Write to r0
    {1'b0, 1'b1, 16'h0009, 16'h0041, 16'h0000, 2'b01, 8'h00, 4'h7, 4'h5},  // Random store
    {1'b0, 1'b0, 16'h000a, 16'h0040, 16'h0000, 2'b10, 8'h8c, 4'h0, 4'h6},  // r8 = mem[40]
    {1'b0, 1'b0, 16'h000b, 16'h0041, 16'h0000, 2'b10, 8'h9c, 4'h1, 4'h2},  // r9 = mem[41]
    {1'b0, 1'b0, 16'h000c, 16'h4321, 16'h0000, 2'b00, 8'h18, 4'h8, 4'h0},  // r1 overwritten
    {1'b0, 1'b1, 16'h000d, 16'h0000, 16'h0000, 2'b00, 8'ha8, 4'h9, 4'h1},  // r10 = random
    {1'b0, 1'b0, 16'h000e, 16'h0bad, 16'h0000, 2'b00, 8'hb8, 4'h1, 4'ha},
    {1'b0, 1'b0, 16'h000f, 16'h0000, 16'h0000, 2'b00, 8'h00, 4'ha, 4'hb},
    {1'b0, 1'b0, 16'h0010, 16'h0000, 16'h0000, 2'b00, 8'h02, 4'hb, 4'h3},  // HLT
    {1'b0, 1'b0, 16'h0011, 16'h1212, 16'h0000, 2'b00, 8'hc8, 4'h1, 4'h2},  // Too late
    {1'b0, 1'b0, 16'h0012, 16'h0040, 16'h2222, 2'b01, 8'h00, 4'h5, 4'h6},  // Store dropped
    {1'b0, 1'b0, 16'h0013, 16'h0040, 16'h0000, 2'b10, 8'hdc, 4'hc, 4'h0},
    {1'b0, 1'b0, 16'h0014, 16'h1414, 16'h0000, 2'b00, 8'he8, 4'hd, 4'h8},
    {1'b0, 1'b0, 16'h0015, 16'h0000, 16'h0000, 2'b00, 8'hf9, 4'he, 4'h9},
    {1'b0, 1'b0, 16'h0016, 16'h0000, 16'h0000, 2'b00, 8'h00, 4'hc, 4'hd},  // Final reads
    {1'b0, 1'b0, 16'h0017, 16'h0000, 16'h0000, 2'b00, 8'h00, 4'hf, 4'ha},
    {1'b0, 1'b0, 16'h0018, 16'h0000, 16'h0000, 2'b00, 8'h00, 4'h1, 4'hb}
  };

  // DUT signals
  logic clk, rst, flush;
  logic [`CPU_DATA_W-1:0] ex_pc_next, ex_alu_out, ex_store_data;
  mem_ctrl_t              ex_mem_ctrl;
  wb_ctrl_t               ex_wb_ctrl;
  logic [`CPU_REG_AW-1:0] rd_addr_a, rd_addr_b, wb_rd;
  logic [`CPU_DATA_W-1:0] rd_data_a, rd_data_b, wb_data;
  logic                   wb_we, halted;

  // Reference model state
  logic [`CPU_DATA_W-1:0] m_regs [`CPU_REG_N];
  logic [`CPU_DATA_W-1:0] m_mem [`CPU_DMEM_WORDS];
  logic                   m_halted;
  logic [`CPU_DATA_W-1:0] s1_pc, s1_alu, s1_store;    // EX/MEM stage
  mem_ctrl_t              s1_mc;
  wb_ctrl_t               s1_wc;
  logic [`CPU_DATA_W-1:0] s2_pc, s2_alu, s2_load;     // MEM/WB stage
  wb_ctrl_t               s2_wc;

  logic [31:0] lcg_state;
  int          checks = 0;
  int          errors = 0;
  int          cycle_count = 0;

  cpu_backend_top i_dut (
    .clk, .rst, .flush,
    .ex_pc_next, .ex_alu_out, .ex_store_data, .ex_mem_ctrl, .ex_wb_ctrl,
    .rd_addr_a, .rd_addr_b, .rd_data_a, .rd_data_b,
    .wb_we, .wb_rd, .wb_data, .halted
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;   // 8 ns period

  // Hard stop if the stimulus loop never completes
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Run stopped after %0d cycles, stimulus did not finish", TIMEOUT_CYCLES);
      $display("*** FAILED ***");
      $finish;
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////
  function automatic logic [15:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];   // Upper bits have the longer period
  endfunction

  function automatic row_t fetch_row(input int idx);
    row_t r;
    r = TABLE[idx];
    if (r.rnd) begin
      r.pc_next = next_random();
      r.store   = next_random();
      if (r.mc == 2'b00) begin
        r.alu = next_random();   // Addresses stay fixed for memory rows
      end
    end
    return r;
  endfunction

  // PCS over load data over ALU result
  function automatic logic [15:0] select_wb_value(input wb_ctrl_t wc,
      input logic [15:0] pc, input logic [15:0] alu, input logic [15:0] ld);
    if (wc.pcs) begin
      return pc;
    end
    return wc.mem_to_reg ? ld : alu;
  endfunction

  function automatic logic model_write_enable();
    return s2_wc.reg_write && (s2_wc.reg_rd != 4'h0) && !m_halted;
  endfunction

  function automatic logic [15:0] expected_read(input logic [3:0] addr, input logic we,
      input logic [15:0] data);
    if (addr == 4'h0) begin
      return '0;                    // r0 is hardwired
    end
    if (we && (s2_wc.reg_rd == addr)) begin
      return data;                  // Bypass of the write in progress
    end
    return m_regs[addr];
  endfunction

  task automatic check_value(input string name, input logic [15:0] got,
      input logic [15:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic drive_inputs(input row_t r);
    flush         = r.flush;
    ex_pc_next    = r.pc_next;
    ex_alu_out    = r.alu;
    ex_store_data = r.store;
    ex_mem_ctrl   = r.mc;
    ex_wb_ctrl    = r.wc;
    rd_addr_a     = r.ra;
    rd_addr_b     = r.rb;
  endtask

  task automatic check_outputs(input row_t r);
    logic        exp_we;
    logic [15:0] exp_data;
    exp_we   = model_write_enable();
    exp_data = select_wb_value(s2_wc, s2_pc, s2_alu, s2_load);
    check_value("wb_we", 16'(wb_we), 16'(exp_we));
    check_value("wb_rd", 16'(wb_rd), 16'(s2_wc.reg_rd));
    check_value("wb_data", wb_data, exp_data);
    check_value("rd_data_a", rd_data_a, expected_read(r.ra, exp_we, exp_data));
    check_value("rd_data_b", rd_data_b, expected_read(r.rb, exp_we, exp_data));
    check_value("halted", 16'(halted), 16'(m_halted));
  endtask

  task automatic reset_model();
    for (int i = 0; i < `CPU_REG_N; i++) begin
      m_regs[i] = '0;
    end
    m_halted = 1'b0;
    {s1_pc, s1_alu, s1_store, s1_mc, s1_wc} = '0;
    {s2_pc, s2_alu, s2_load, s2_wc} = '0;
  endtask

  // One clock edge of the two-stage delay line, old state used throughout
  task automatic advance_model(input row_t r);
    logic        we;
    logic [15:0] wd;
    logic [15:0] ld;
    logic        hlt_now;
    we      = model_write_enable();
    wd      = select_wb_value(s2_wc, s2_pc, s2_alu, s2_load);
    hlt_now = s2_wc.hlt;
    ld      = '0;
    if (s1_mc.mem_read && !m_halted) begin
      ld = m_mem[s1_alu[`CPU_DMEM_AW-1:0]];   // Read before the store lands
    end
    if (s1_mc.mem_write && !m_halted) begin
      m_mem[s1_alu[`CPU_DMEM_AW-1:0]] = s1_store;
    end
    if (we) begin
      m_regs[s2_wc.reg_rd] = wd;
    end
    s2_pc   = s1_pc;
    s2_alu  = s1_alu;
    s2_load = ld;
    s2_wc   = m_halted ? '0 : s1_wc;
    s1_pc    = r.pc_next;
    s1_alu   = r.alu;
    s1_store = r.store;
    s1_mc    = (r.flush || m_halted) ? '0 : r.mc;   // Bubble
    s1_wc    = (r.flush || m_halted) ? '0 : r.wc;
    m_halted = m_halted | hlt_now;
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    row_t row;
    rst           = 1'b1;
    flush         = 1'b0;
    ex_pc_next    = '0;
    ex_alu_out    = '0;
    ex_store_data = '0;
    ex_mem_ctrl   = '0;
    ex_wb_ctrl    = '0;
    rd_addr_a     = '0;
    rd_addr_b     = '0;
    lcg_state     = SEED;
    reset_model();
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int i = 0; i < NROWS; i++) begin
      row = fetch_row(i);
      drive_inputs(row);   // 1 ns after the edge
      #5;
      check_outputs(row);  // Settled, 2 ns before the next edge
      @(posedge clk);
      advance_model(row);
      #1;
    end
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+src
src/cpu_pkg.sv
src/ex_mem_pipe_reg.sv
src/data_memory.sv
src/mem_wb_pipe_reg.sv
src/write_back_regfile.sv
src/cpu_backend_top.sv
bench/cpu_backend_sva.sv
bench/cpu_backend_tb.sv

//--- Makefile
# Verilator build and run for the CPU back end testbench

SIM  = obj_dir/Vcpu_backend_tb
SRCS = compile.f $(wildcard src/*.sv src/*.svh bench/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module cpu_backend_tb -f compile.f

run: $(SIM)
	./$(SIM) 2>&1 | tee sim.log
	@if grep -q '\*\*\* FAILED \*\*\*' sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' sim.log || { echo "Run ended without a result"; exit 1; }

clean:
	rm -rf obj_dir sim.log
